// ==== list.f ====
logic/fdiv_pkg.sv
logic/fdiv_classify.sv
logic/fdiv_mant_div.sv
logic/fdiv_round.sv
logic/fdiv_ctrl.sv
logic/fdiv_top.sv
sim/fdiv_clk_gen.sv
sim/fdiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module fdiv_tb -f list.f -o fdiv_sim &&
./obj_dir/fdiv_sim || { echo "simulation did not pass"; exit 1; }

// ==== sim/fdiv_tb.sv ====
// Half-precision divider testbench
`timescale 1ns/100ps
`default_nettype none

module fdiv_tb;
    import fdiv_pkg::*;

    localparam int N_REQ          = 60;
    localparam int TIMEOUT_CYCLES = N_REQ * (FDIV_LATENCY + 8) + 200;

    logic        core_clk, core_reset_n;
    logic        req_valid, req_ready, result_valid, result_stall, pending;
    fdiv_req_t   req;
    fdiv_resp_t  resp, exp_head;
    fdiv_resp_t  exp_q[$];
    tag_t        tag_cnt = '0;
    logic [31:0] rnd = 32'd27;
    int          n_sent = 0, n_done = 0, lat_cnt = 0, cycle_cnt = 0;

    fdiv_clk_gen clk_gen_i (.core_clk(core_clk), .core_reset_n(core_reset_n));

    fdiv_top dut_i (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .result_valid(result_valid), .resp(resp), .result_stall(result_stall)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                   input logic [15:0] got_v);
        $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
        $display("test failed");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        $display("test failed");
        $fatal(1, "check failed");
    endtask

    // sends one request and waits out its result with a random stall
    task automatic do_req(input half_t a, input half_t b, input round_mode_e rm,
                          input half_t ex_data, input fflags_t ex_flags);
        int stall_len;
        rnd = lcg_next(rnd);
        stall_len = int'(rnd[29:27]);
        exp_q.push_back(fdiv_resp_t'{data: ex_data, flags: ex_flags, tag: tag_cnt});
        exp_head = exp_q[0];
        pending = 1'b1;
        while (!req_ready) @(negedge core_clk);
        req = '{op_a: a, op_b: b, rm: rm, tag: tag_cnt};
        req_valid = 1'b1;
        result_stall = (stall_len != 0);
        n_sent++;
        @(negedge core_clk);
        req_valid = 1'b0;
        while (!result_valid) @(negedge core_clk);
        repeat (stall_len) @(negedge core_clk);
        result_stall = 1'b0;
        @(negedge core_clk);                    // result has left
        void'(exp_q.pop_front());
        pending = (exp_q.size() != 0);
        tag_cnt++;
    endtask

    always @(posedge core_clk) begin
        lat_cnt <= (req_valid && req_ready) ? 0 : lat_cnt + 1;
        cycle_cnt <= cycle_cnt + 1;
        if (result_valid && !result_stall) begin
            n_done <= n_done + 1;               // one per result leaving
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("test failed");
            $fatal(1, "timeout after %0d cycles", TIMEOUT_CYCLES);
        end
    end

    a_reset_state: assert property (@(posedge core_clk)
        $rose(core_reset_n) |-> req_ready && !result_valid)
        else report_failure("wrong req_ready or result_valid after reset");
    a_expected: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid |-> pending)
        else report_failure("result_valid without an outstanding request");
    a_data: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid && !result_stall |-> resp.data == exp_head.data)
        else report_mismatch("resp.data", exp_head.data, resp.data);
    a_flags: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid && !result_stall |-> resp.flags == exp_head.flags)
        else report_mismatch("resp.flags", 16'(exp_head.flags), 16'(resp.flags));
    a_tag: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid && !result_stall |-> resp.tag == exp_head.tag)
        else report_mismatch("resp.tag", 16'(exp_head.tag), 16'(resp.tag));
    a_latency: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        $rose(result_valid) |-> lat_cnt == FDIV_LATENCY)
        else report_mismatch("result_valid latency", 16'(FDIV_LATENCY), 16'(lat_cnt));
    a_stall: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid && result_stall |=> result_valid && !req_ready && $stable(resp))
        else report_failure("resp or req_ready changed while result_stall was high");

    initial begin
        half_t a, b, ex;
        int    ea, eb;
        req_valid = 1'b0;
        req = '0;
        result_stall = 1'b0;
        pending = 1'b0;
        exp_head = '0;
        @(posedge core_reset_n);
        @(negedge core_clk);
        // exact quotients by powers of two, by one and x/x
        for (int i = 0; i < 30; i++) begin
            rnd = lcg_next(rnd);
            a = {rnd[31], 5'd0, rnd[25:16]};
            rnd = lcg_next(rnd);
            ea = 1 + int'(rnd[30:26]) % 30;
            a[14:10] = 5'(ea);
            do begin
                rnd = lcg_next(rnd);
                eb = 1 + int'(rnd[30:26]) % 30;
            end while (ea - eb + 15 < 1 || ea - eb + 15 > 30);
            if (i % 3 == 1) eb = 15;
            b = (i % 3 == 2) ? a : {rnd[20] && (i % 3 == 0), 5'(eb), 10'd0};
            ex = (i % 3 == 2) ? 16'h3C00 : {a[15] ^ b[15], 5'(ea - eb + 15), a[9:0]};
            do_req(a, b, round_mode_e'(3'(int'(rnd[23:20]) % 5)), ex, 5'b00000);
        end
        // 1/3 in every rounding mode
        do_req(16'h3C00, 16'h4200, RNE, 16'h3555, 5'b00001);
        do_req(16'h3C00, 16'h4200, RTZ, 16'h3555, 5'b00001);
        do_req(16'h3C00, 16'h4200, RDN, 16'h3555, 5'b00001);
        do_req(16'h3C00, 16'h4200, RMM, 16'h3555, 5'b00001);
        do_req(16'h3C00, 16'h4200, RUP, 16'h3556, 5'b00001);
        do_req(16'hBC00, 16'h4200, RDN, 16'hB556, 5'b00001);
        do_req(16'hBC00, 16'h4200, RUP, 16'hB555, 5'b00001);
        // special operands
        do_req(16'h3C00, 16'h0000, RNE, 16'h7C00, 5'b01000);
        do_req(16'hC000, 16'h0000, RTZ, 16'hFC00, 5'b01000);
        do_req(16'h0000, 16'h0000, RNE, 16'h7E00, 5'b10000);
        do_req(16'h7C00, 16'hFC00, RUP, 16'h7E00, 5'b10000);
        do_req(16'h7E00, 16'h3C00, RNE, 16'h7E00, 5'b00000);
        do_req(16'h7D00, 16'h3C00, RDN, 16'h7E00, 5'b10000);
        do_req(16'h0000, 16'hC000, RNE, 16'h8000, 5'b00000);
        do_req(16'h4000, 16'h7C00, RMM, 16'h0000, 5'b00000);
        // overflow and underflow
        do_req(16'h7BFF, 16'h1400, RNE, 16'h7C00, 5'b00101);
        do_req(16'h7BFF, 16'h1400, RTZ, 16'h7BFF, 5'b00101);
        do_req(16'h0400, 16'h7800, RNE, 16'h0000, 5'b00011);
        repeat (4) @(negedge core_clk);
        if (n_done == n_sent) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "%0d results left for %0d requests", n_done, n_sent);
        end
    end

endmodule

`default_nettype wire

// ==== sim/fdiv_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module fdiv_clk_gen (
    output logic core_clk,
    output logic core_reset_n
);

    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;        // 4 ns period
    end

    initial begin
        core_reset_n = 1'b0;
        repeat (16) @(posedge core_clk);
        @(negedge core_clk);
        core_reset_n = 1'b1;                    // released between rising edges
    end

endmodule

`default_nettype wire

// ==== logic/fdiv_top.sv ====
// Half-precision divider top level
`timescale 1ns/100ps
`default_nettype none

module fdiv_top (
    input  logic                 core_clk,
    input  logic                 core_reset_n,
    input  logic                 req_valid,
    input  fdiv_pkg::fdiv_req_t  req,
    output logic                 req_ready,
    output logic                 result_valid,
    output fdiv_pkg::fdiv_resp_t resp,
    input  logic                 result_stall
);
    import fdiv_pkg::*;

    fdiv_class_t cls;
    fdiv_class_t cls_q;         // captured at acceptance
    round_mode_e rm_q;
    logic        div_start;
    logic        div_done;
    quo_t        quo;
    logic        sticky;
    half_t       resp_data;
    fflags_t     resp_flags;

    fdiv_classify classify_i (.req(req), .cls(cls));

    fdiv_ctrl ctrl_i (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .cls(cls), .cls_q(cls_q), .rm_q(rm_q),
        .div_start(div_start), .div_done(div_done),
        .resp_data(resp_data), .resp_flags(resp_flags),
        .result_valid(result_valid), .resp(resp), .result_stall(result_stall)
    );

    fdiv_mant_div mant_div_i (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .start(div_start), .man_a(cls_q.man_a), .man_b(cls_q.man_b),
        .done(div_done), .quo(quo), .sticky(sticky)
    );

    fdiv_round round_i (
        .cls(cls_q), .rm(rm_q), .quo(quo), .sticky(sticky),
        .resp_data(resp_data), .resp_flags(resp_flags)
    );

endmodule

`default_nettype wire

// ==== logic/fdiv_ctrl.sv ====
// Divider request and result control
`timescale 1ns/100ps
`default_nettype none

module fdiv_ctrl (
    input  logic                  core_clk,
    input  logic                  core_reset_n,
    input  logic                  req_valid,
    input  fdiv_pkg::fdiv_req_t   req,
    output logic                  req_ready,
    input  fdiv_pkg::fdiv_class_t cls,
    output fdiv_pkg::fdiv_class_t cls_q,
    output fdiv_pkg::round_mode_e rm_q,
    output logic                  div_start,
    input  logic                  div_done,
    input  fdiv_pkg::half_t       resp_data,
    input  fdiv_pkg::fflags_t     resp_flags,
    output logic                  result_valid,
    output fdiv_pkg::fdiv_resp_t  resp,
    input  logic                  result_stall
);
    import fdiv_pkg::*;

    typedef enum logic [1:0] {IDLE, BUSY, HOLD} ctrl_state_e;

    ctrl_state_e state;
    tag_t        tag_q;
    logic        accept;

    assign req_ready    = (state == IDLE);
    assign accept       = req_valid && req_ready;
    assign result_valid = (state == HOLD);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state     <= IDLE;
            div_start <= 1'b0;
        end else begin
            div_start <= accept;            // one cycle after capture
            case (state)
                IDLE: if (accept) state <= BUSY;
                BUSY: if (div_done) state <= HOLD;   // specials wait too
                HOLD: if (!result_stall) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            cls_q <= cls;
            rm_q  <= req.rm;
            tag_q <= req.tag;
        end
        if (div_done) begin
            resp <= '{data: resp_data, flags: resp_flags, tag: tag_q};
        end
    end

    a_resp_held: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        result_valid && result_stall |=> result_valid && $stable(resp));

    // no new request and no result until the fixed latency has run out
    a_latency: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        accept |=> (!req_ready && !result_valid) [*FDIV_LATENCY] ##1 result_valid);

    a_done_busy: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        div_done |-> state == BUSY);

endmodule

`default_nettype wire

// ==== logic/fdiv_round.sv ====
// Normalize, round and pack the quotient
`timescale 1ns/100ps
`default_nettype none

module fdiv_round (
    input  fdiv_pkg::fdiv_class_t cls,
    input  fdiv_pkg::round_mode_e rm,
    input  fdiv_pkg::quo_t        quo,
    input  logic                  sticky,
    output fdiv_pkg::half_t       resp_data,
    output fdiv_pkg::fflags_t     resp_flags
);
    import fdiv_pkg::*;

    logic        sign;
    logic        norm;          // quotient below one, needs a left shift
    mant_t       mant;
    logic        guard;
    logic        sticky_all;
    logic        inexact;
    logic        round_up;
    logic        ovf_to_inf;
    logic [11:0] mant_r;
    sexp_t       exp_r;

    assign sign = cls.sign;
    assign norm = !quo[QUO_BITS-1];

    assign mant       = norm ? quo[QUO_BITS-2:1] : quo[QUO_BITS-1:2];
    assign guard      = norm ? quo[0] : quo[1];
    assign sticky_all = (!norm && quo[0]) || sticky;    // round bit folds into sticky
    assign inexact    = guard || sticky_all;

    always_comb begin
        case (rm)
            RNE:     round_up = guard && (sticky_all || mant[0]);
            RTZ:     round_up = 1'b0;
            RDN:     round_up = sign && inexact;
            RUP:     round_up = !sign && inexact;
            RMM:     round_up = guard;
            default: round_up = 1'b0;
        endcase
    end

    assign mant_r = {1'b0, mant} + {11'd0, round_up};

    // carry out of the mantissa bumps the exponent, fraction is then zero
    assign exp_r = cls.exp_diff - sexp_t'({7'd0, norm}) + sexp_t'(EXP_BIAS)
                   + sexp_t'({7'd0, mant_r[11]});

    always_comb begin
        case (rm)
            RTZ:     ovf_to_inf = 1'b0;
            RDN:     ovf_to_inf = sign;
            RUP:     ovf_to_inf = !sign;
            default: ovf_to_inf = 1'b1;     // nearest modes
        endcase
    end

    always_comb begin
        resp_data  = {sign, exp_r[4:0], mant_r[9:0]};
        resp_flags = '0;
        if (cls.is_special) begin
            resp_data  = cls.special_data;
            resp_flags = cls.special_flags;
        end else if (exp_r > sexp_t'(30)) begin
            resp_data = {sign, ovf_to_inf ? POS_INF : MAX_FINITE};
            resp_flags[FLAG_OF] = 1'b1;
            resp_flags[FLAG_NX] = 1'b1;
        end else if (exp_r < sexp_t'(1)) begin
            resp_data = {sign, 15'd0};      // flush to signed zero
            resp_flags[FLAG_UF] = 1'b1;
            resp_flags[FLAG_NX] = 1'b1;
        end else begin
            resp_flags[FLAG_NX] = inexact;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fdiv_mant_div.sv ====
// Radix-2 restoring mantissa divider
`timescale 1ns/100ps
`default_nettype none

module fdiv_mant_div (
    input  logic            core_clk,
    input  logic            core_reset_n,
    input  logic            start,
    input  fdiv_pkg::mant_t man_a,
    input  fdiv_pkg::mant_t man_b,
    output logic            done,
    output fdiv_pkg::quo_t  quo,
    output logic            sticky
);
    import fdiv_pkg::*;

    logic [11:0] rem;           // partial remainder, one bit over the divisor
    mant_t       divisor;
    logic [3:0]  cnt;
    logic        busy;
    logic [11:0] diff;
    logic        q_bit;

    assign diff   = rem - {1'b0, divisor};
    assign q_bit  = (rem >= {1'b0, divisor});
    assign sticky = |rem;       // nonzero remainder means inexact

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'(QUO_BITS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (start) begin
            rem     <= {1'b0, man_a};
            divisor <= man_b;
        end else if (busy) begin
            rem <= q_bit ? {diff[10:0], 1'b0} : {rem[10:0], 1'b0};
            quo <= {quo[QUO_BITS-2:0], q_bit};   // first bit is the integer bit
        end
    end

    a_no_restart: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        start |-> !busy);

endmodule

`default_nettype wire

// ==== logic/fdiv_classify.sv ====
// Operand decode and special results
`timescale 1ns/100ps
`default_nettype none

module fdiv_classify (
    input  fdiv_pkg::fdiv_req_t   req,
    output fdiv_pkg::fdiv_class_t cls
);
    import fdiv_pkg::*;

    exp_t       exp_a;
    exp_t       exp_b;
    logic [9:0] frac_a;
    logic [9:0] frac_b;
    logic       nan_a, nan_b;
    logic       snan_a, snan_b;
    logic       inf_a, inf_b;
    logic       zero_a, zero_b;
    logic       sign;

    assign exp_a  = req.op_a[14:10];
    assign exp_b  = req.op_b[14:10];
    assign frac_a = req.op_a[9:0];
    assign frac_b = req.op_b[9:0];
    assign sign   = req.op_a[15] ^ req.op_b[15];

    assign nan_a  = (exp_a == 5'h1f) && (frac_a != 10'd0);
    assign nan_b  = (exp_b == 5'h1f) && (frac_b != 10'd0);
    assign snan_a = nan_a && !frac_a[9];    // quiet bit clear
    assign snan_b = nan_b && !frac_b[9];
    assign inf_a  = (exp_a == 5'h1f) && (frac_a == 10'd0);
    assign inf_b  = (exp_b == 5'h1f) && (frac_b == 10'd0);
    assign zero_a = (exp_a == 5'd0);        // subnormals flushed here
    assign zero_b = (exp_b == 5'd0);

    always_comb begin
        cls               = '0;
        cls.sign          = sign;
        cls.is_special    = 1'b1;
        cls.exp_diff      = sexp_t'({3'b000, exp_a}) - sexp_t'({3'b000, exp_b});
        cls.man_a         = {1'b1, frac_a};
        cls.man_b         = {1'b1, frac_b};
        if (nan_a || nan_b || (zero_a && zero_b) || (inf_a && inf_b)) begin
            cls.special_data = CANON_NAN;
            cls.special_flags[FLAG_NV] = snan_a || snan_b || (zero_a && zero_b)
                                         || (inf_a && inf_b);
        end else if (zero_b && !inf_a && !zero_a) begin
            cls.special_data = {sign, POS_INF};
            cls.special_flags[FLAG_DZ] = 1'b1;
        end else if (inf_a) begin
            cls.special_data = {sign, POS_INF};
        end else if (zero_a || inf_b) begin
            cls.special_data = {sign, 15'd0};
        end else begin
            cls.is_special = 1'b0;      // both operands normal
        end
    end

endmodule

`default_nettype wire

// ==== logic/fdiv_pkg.sv ====
// Half-precision divider types
`default_nettype none

package fdiv_pkg;

    localparam int QUO_BITS     = 13;       // 11 significand bits, guard, round
    localparam int EXP_BIAS     = 15;
    localparam int FDIV_LATENCY = 15;       // accepting edge to result_valid

    // flag bit positions
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    typedef logic [15:0]         half_t;
    typedef logic [4:0]          exp_t;
    typedef logic signed [7:0]   sexp_t;    // working exponent, room for over/underflow
    typedef logic [10:0]         mant_t;    // hidden bit included
    typedef logic [QUO_BITS-1:0] quo_t;
    typedef logic [4:0]          tag_t;
    typedef logic [4:0]          fflags_t;  // nv dz of uf nx

    localparam half_t       CANON_NAN  = 16'h7E00;
    localparam logic [14:0] MAX_FINITE = 15'h7BFF;  // magnitude only
    localparam logic [14:0] POS_INF    = 15'h7C00;  // magnitude only

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } round_mode_e;

    typedef struct packed {
        half_t       op_a;
        half_t       op_b;
        round_mode_e rm;
        tag_t        tag;
    } fdiv_req_t;

    typedef struct packed {
        half_t   data;
        fflags_t flags;
        tag_t    tag;
    } fdiv_resp_t;

    typedef struct packed {
        logic    sign;              // sign of the quotient
        logic    is_special;        // result fixed by operand decode
        half_t   special_data;
        fflags_t special_flags;
        sexp_t   exp_diff;          // unbiased exponent difference
        mant_t   man_a;
        mant_t   man_b;
    } fdiv_class_t;

endpackage

`default_nettype wire
